/* d_cache.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/sram_bank.sv
hdl/cache_way.sv
hdl/miss_ctrl.sv
hdl/way_select.sv
hdl/d_cache.sv
dv/d_cache_asserts.sv
dv/d_cache_tb.sv

/* Makefile */
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := d_cache_tb
FLIST := d_cache.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* dv/d_cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module d_cache_tb;

    localparam int n_ops = 25;

    typedef struct packed {
        logic        store;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
    } op_t;

    // store flag, address, byte strobes, write data
    op_t ops [n_ops] = '{
        '{1'b0, 32'h0000_0014, 4'h0, 32'h0000_0000},   // cold miss, set 1
        '{1'b0, 32'h0000_0014, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_0018, 4'h0, 32'h0000_0000},
        '{1'b1, 32'h0000_0018, 4'hf, 32'ha5a5_1234},
        '{1'b1, 32'h0000_001c, 4'h3, 32'h1111_beef},
        '{1'b1, 32'h0000_0010, 4'h8, 32'h7722_3344},
        '{1'b0, 32'h0000_0018, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_001c, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_0010, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_0034, 4'h0, 32'h0000_0000},   // set 3 fills up
        '{1'b1, 32'h0000_0138, 4'hf, 32'hcafe_0138},   // store miss
        '{1'b0, 32'h0000_0230, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_033c, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_0034, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_0430, 4'h0, 32'h0000_0000},   // evicts the dirty line
        '{1'b0, 32'h0000_0138, 4'h0, 32'h0000_0000},
        '{1'b1, 32'h0000_013c, 4'h3, 32'h5555_aaaa},
        '{1'b0, 32'h0000_033c, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_0530, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_0630, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_0730, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_013c, 4'h0, 32'h0000_0000},
        '{1'b1, 32'h0000_0044, 4'h3, 32'h1234_5678},   // allocate on store
        '{1'b0, 32'h0000_0044, 4'h0, 32'h0000_0000},
        '{1'b0, 32'h0000_004c, 4'h0, 32'h0000_0000}
    };

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] addr;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        resp;
    logic [31:0] rdata;
    logic        busy;
    logic [31:0] ar_addr;
    logic        ar_valid;
    logic        ar_ready;
    logic [31:0] r_data;
    logic        r_valid;
    logic        r_last;
    logic [31:0] aw_addr;
    logic        aw_valid;
    logic        aw_ready;
    logic [31:0] w_data;
    logic        w_valid;
    logic        w_ready;
    logic        w_last;
    logic        b_valid;

    logic [31:0]          mem [256];
    logic [31:0]          shadow [256];   // memory as the core sees it
    logic [31:0]          bus_log [$];    // burst addresses, low bit marks a write-back
    logic [31:0]          lfsr;
    int                   stall;
    int                   errors;
    int                   checks;
    logic                 m_valid [16][`DC_WAYS];
    logic                 m_dirty [16][`DC_WAYS];
    logic [`DC_TAG_W-1:0] m_tag [16][`DC_WAYS];
    logic [2:0]           m_lru [16];

    d_cache dut0 (.*);

    bind d_cache d_cache_asserts asserts0 (
        .clk(clk), .rst(rst), .req(req), .busy(busy), .resp(resp),
        .ar_valid(ar_valid), .ar_ready(ar_ready),
        .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w_valid(w_valid), .w_ready(w_ready), .w_last(w_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // 1 KB model folded so sets 0-7 with tags 0-7 never alias
    function automatic int mem_idx(input logic [31:0] a);
        return int'({a[10:8], a[6:2]});
    endfunction

    function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                               input logic [3:0]  strb,
                                               input logic [31:0] new_word);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // reference cache state, tree-LRU per set
    task automatic model_access(input logic [31:0] a, input logic store,
                                output logic hit, output logic wb,
                                output logic [31:0] wb_addr);
        int set;
        int way;
        set     = int'(a[7:4]);
        way     = -1;
        wb      = 1'b0;
        wb_addr = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == a[31 -: `DC_TAG_W]) begin
                way = w;
            end
        end
        hit = (way >= 0);
        if (!hit) begin
            if (m_lru[set][0]) begin    // root picks the half, leaf the way
                way = m_lru[set][2] ? 3 : 2;
            end else begin
                way = m_lru[set][1] ? 1 : 0;
            end
            wb      = m_valid[set][way] && m_dirty[set][way];
            wb_addr = {m_tag[set][way], a[7:4], 4'h0};
            m_valid[set][way] = 1'b1;
            m_tag[set][way]   = a[31 -: `DC_TAG_W];
            m_dirty[set][way] = 1'b0;
        end
        if (store) begin
            m_dirty[set][way] = 1'b1;
        end
        m_lru[set][0] = (way < 2);      // point away from the touched way
        if (way < 2) begin
            m_lru[set][1] = (way == 0);
        end else begin
            m_lru[set][2] = (way == 2);
        end
    endtask

    task automatic serve_read();
        logic [31:0] base;
        base = ar_addr;
        bus_log.push_back(base);
        repeat (stall) @(posedge clk);
        ar_ready <= 1'b1;
        @(posedge clk);
        ar_ready <= 1'b0;
        for (int i = 0; i < `DC_WORDS; i++) begin
            repeat (stall) @(posedge clk);   // gap before each beat
            r_valid <= 1'b1;
            r_data  <= mem[mem_idx(base + 32'(4 * i))];
            r_last  <= (i == `DC_WORDS - 1);
            @(posedge clk);
            r_valid <= 1'b0;
            r_last  <= 1'b0;
        end
    endtask

    task automatic serve_write();
        logic [31:0] base;
        int          idx;
        base = aw_addr;
        bus_log.push_back(base | 32'h1);
        repeat (stall) @(posedge clk);
        aw_ready <= 1'b1;
        @(posedge clk);
        aw_ready <= 1'b0;
        for (int i = 0; i < `DC_WORDS; i++) begin
            repeat (stall) @(posedge clk);
            w_ready <= 1'b1;
            @(posedge clk);
            w_ready <= 1'b0;
            idx = mem_idx(base + 32'(4 * i));
            check_val($sformatf("write-back word %0d of %h", i, base), shadow[idx], w_data);
            mem[idx] = w_data;
        end
        repeat (stall) @(posedge clk);
        b_valid <= 1'b1;
        @(posedge clk);
        b_valid <= 1'b0;
    endtask

    initial begin : bus_model
        ar_ready = 1'b0;
        r_data   = '0;
        r_valid  = 1'b0;
        r_last   = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && ar_valid) begin
                serve_read();
            end else if (!rst && aw_valid) begin
                serve_write();
            end
        end
    end

    initial begin : watchdog
        repeat (n_ops * 200 + 50) @(posedge clk);
        $display("timeout: the DUT stopped answering requests");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        op_t         op;
        logic        exp_hit;
        logic        exp_wb;
        logic [31:0] wb_addr;
        logic [31:0] exp_bus [$];
        int          idx;
        int          lat;
        rst    = 1'b1;
        req    = 1'b0;
        addr   = '0;
        wstrb  = '0;
        wdata  = '0;
        errors = 0;
        checks = 0;
        lfsr   = 32'h289149d2;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = rand_bits(32);
            shadow[i] = mem[i];
        end
        stall = 1 + int'(rand_bits(2));      // same ready delay for the whole run
        for (int s = 0; s < 16; s++) begin
            m_lru[s] = '0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_val("reset busy", 32'h0, 32'(busy));
        check_val("reset resp", 32'h0, 32'(resp));
        check_val("reset ar_valid", 32'h0, 32'(ar_valid));
        check_val("reset aw_valid", 32'h0, 32'(aw_valid));
        check_val("reset w_valid", 32'h0, 32'(w_valid));
        for (int i = 0; i < n_ops; i++) begin
            op  = ops[i];
            idx = mem_idx(op.addr);
            model_access(op.addr, op.store, exp_hit, exp_wb, wb_addr);
            if (op.store) begin
                shadow[idx] = byte_merge(shadow[idx], op.strb, op.data);
            end
            exp_bus.delete();
            if (!exp_hit) begin
                if (exp_wb) begin
                    exp_bus.push_back(wb_addr | 32'h1);   // victim goes out first
                end
                exp_bus.push_back({op.addr[31:4], 4'h0});
            end
            bus_log.delete();
            req   <= 1'b1;
            addr  <= op.addr;
            wstrb <= op.store ? op.strb : 4'h0;
            wdata <= op.data;
            @(posedge clk);
            req <= 1'b0;
            lat = 0;
            do begin
                @(posedge clk);
                lat++;
            end while (!resp);
            check_val($sformatf("op %0d rdata", i), shadow[idx], rdata);
            // a hit never raises busy, a miss holds it through resp
            check_val($sformatf("op %0d busy at resp", i), exp_hit ? 32'h0 : 32'h1,
                      32'(busy));
            if (exp_hit) begin
                check_val($sformatf("op %0d hit latency", i), 32'd1, lat);
            end
            check_val($sformatf("op %0d burst count", i),
                      32'(exp_bus.size()), 32'(bus_log.size()));
            for (int j = 0; j < exp_bus.size() && j < bus_log.size(); j++) begin
                check_val($sformatf("op %0d burst %0d", i, j), exp_bus[j], bus_log[j]);
            end
            @(posedge clk);
            check_val($sformatf("op %0d single resp", i), 32'h0, 32'(resp));
            while (busy) @(posedge clk);
        end
        errors += dut0.asserts0.fails;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/d_cache_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module d_cache_asserts (
    input wire clk,
    input wire rst,
    input wire req,
    input wire busy,
    input wire resp,
    input wire ar_valid,
    input wire ar_ready,
    input wire aw_valid,
    input wire aw_ready,
    input wire w_valid,
    input wire w_ready,
    input wire w_last
);

    logic [1:0] w_beats;    // beats taken so far in this burst
    int         fails = 0;  // failed assertions, summed by the testbench

    always_ff @(posedge clk) begin
        if (rst) begin
            w_beats <= '0;
        end else if (w_valid && w_ready) begin
            w_beats <= w_beats + 2'd1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid)
        else begin
            $error("ar_valid dropped before ar_ready");
            fails++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid)
        else begin
            $error("aw_valid dropped before aw_ready");
            fails++;
        end

    // last flag only on beat four
    w_last_beat: assert property (@(posedge clk) disable iff (rst)
        w_valid && w_ready |-> (w_last == (w_beats == 2'd3)))
        else begin
            $error("w_last not on the fourth write beat");
            fails++;
        end

    no_resp_on_req: assert property (@(posedge clk) disable iff (rst)
        req |-> !resp)
        else begin
            $error("resp while a request is being taken");
            fails++;
        end

    no_req_busy: assert property (@(posedge clk) disable iff (rst)
        req |-> !busy)
        else begin
            $error("request arrived while the cache is busy");
            fails++;
        end

endmodule

`default_nettype wire

/* hdl/d_cache.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module d_cache (
    input  wire         clk,
    input  wire         rst,
    input  wire         req,
    input  wire [31:0]  addr,
    input  wire [3:0]   wstrb,
    input  wire [31:0]  wdata,
    output logic        resp,
    output logic [31:0] rdata,
    output logic        busy,
    output logic [31:0] ar_addr,
    output logic        ar_valid,
    input  wire         ar_ready,
    input  wire [31:0]  r_data,
    input  wire         r_valid,
    input  wire         r_last,
    output logic [31:0] aw_addr,
    output logic        aw_valid,
    input  wire         aw_ready,
    output logic [31:0] w_data,
    output logic        w_valid,
    input  wire         w_ready,
    output logic        w_last,
    input  wire         b_valid
);
    import dcache_pkg::*;

    logic                          rd_en;
    logic [`DC_INDEX_W-1:0]        rd_idx;
    logic [`DC_INDEX_W-1:0]        wr_idx;      // captured set
    logic [`DC_WAYS-1:0]           tag_we;
    logic [`DC_WAYS-1:0]           line_we;
    logic [`DC_WAYS-1:0]           dirty_we;
    tag_entry_t                    tag_wr;
    line_t                         line_wr;
    logic                          dirty_val;
    wire tag_entry_t [`DC_WAYS-1:0] tags;
    wire line_t [`DC_WAYS-1:0]     lines;
    wire [`DC_WAYS-1:0]            dirties;
    logic [`DC_TAG_W-1:0]          req_tag;
    logic [`DC_OFFSET_W-3:0]       req_offset;
    logic                          hit;
    way_id_t                       hit_way;
    logic [31:0]                   hit_word;
    way_id_t                       victim_way;
    logic                          victim_dirty;
    logic [`DC_TAG_W-1:0]          victim_tag;
    line_t                         victim_line;
    logic                          touch;
    way_id_t                       touch_way;

    miss_ctrl ctrl0 (.*);

    for (genvar g = 0; g < `DC_WAYS; g++) begin : g_way
        cache_way way0 (
            .clk      (clk),
            .rst      (rst),
            .rd_en    (rd_en),
            .rd_idx   (rd_idx),
            .tag_we   (tag_we[g]),
            .wr_idx   (wr_idx),
            .tag_wr   (tag_wr),
            .line_we  (line_we[g]),
            .line_wr  (line_wr),
            .dirty_we (dirty_we[g]),
            .dirty_val(dirty_val),
            .tag_rd   (tags[g]),
            .line_rd  (lines[g]),
            .dirty_rd (dirties[g])
        );
    end

    way_select sel0 (
        .touch_idx(wr_idx),     // LRU works on the captured set
        .rd_idx   (wr_idx),
        .*
    );

endmodule

`default_nettype wire

/* hdl/way_select.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module way_select (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire dcache_pkg::tag_entry_t [`DC_WAYS-1:0]   tags,
    input  wire dcache_pkg::line_t [`DC_WAYS-1:0]        lines,
    input  wire [`DC_WAYS-1:0]                           dirties,
    input  wire [`DC_TAG_W-1:0]                          req_tag,
    input  wire [`DC_OFFSET_W-3:0]                       req_offset,
    input  wire                                          touch,
    input  wire dcache_pkg::way_id_t                     touch_way,
    input  wire [`DC_INDEX_W-1:0]                        touch_idx,
    input  wire [`DC_INDEX_W-1:0]                        rd_idx,
    output logic                                         hit,
    output dcache_pkg::way_id_t                          hit_way,
    output logic [31:0]                                  hit_word,
    output dcache_pkg::way_id_t                          victim_way,
    output logic                                         victim_dirty,
    output logic [`DC_TAG_W-1:0]                         victim_tag,
    output dcache_pkg::line_t                            victim_line
);
    import dcache_pkg::*;

    logic [`DC_WAYS-1:0] hit_vec;
    logic [2:0]          lru_q [1 << `DC_INDEX_W];   // root, left leaf, right leaf
    logic [2:0]          lru_rd;
    way_id_t             line_way;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = tags[w].valid && (tags[w].tag == req_tag);
            if (hit_vec[w]) begin
                hit_way = way_id_t'(w);
            end
        end
    end

    assign hit      = |hit_vec;
    assign hit_word = lines[hit_way][req_offset];

    // root picks the half, the leaf picks the way
    assign lru_rd     = lru_q[rd_idx];
    assign victim_way = {lru_rd[0], lru_rd[0] ? lru_rd[2] : lru_rd[1]};

    assign victim_dirty = dirties[victim_way] && tags[victim_way].valid;
    assign victim_tag   = tags[victim_way].tag;

    // on a hit this is the hit line, for the store merge
    assign line_way    = hit ? hit_way : victim_way;
    assign victim_line = lines[line_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < (1 << `DC_INDEX_W); s++) begin
                lru_q[s] <= '0;
            end
        end else if (touch) begin
            lru_q[touch_idx][0] <= ~touch_way[1];    // point at the other half
            if (touch_way[1]) begin
                lru_q[touch_idx][2] <= ~touch_way[0];
            end else begin
                lru_q[touch_idx][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/miss_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module miss_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req,
    input  wire [31:0]                  addr,
    input  wire [3:0]                   wstrb,
    input  wire [31:0]                  wdata,
    output logic                        resp,
    output logic [31:0]                 rdata,
    output logic                        busy,
    output logic [31:0]                 ar_addr,
    output logic                        ar_valid,
    input  wire                         ar_ready,
    input  wire [31:0]                  r_data,
    input  wire                         r_valid,
    input  wire                         r_last,
    output logic [31:0]                 aw_addr,
    output logic                        aw_valid,
    input  wire                         aw_ready,
    output logic [31:0]                 w_data,
    output logic                        w_valid,
    input  wire                         w_ready,
    output logic                        w_last,
    input  wire                         b_valid,
    output logic                        rd_en,
    output logic [`DC_INDEX_W-1:0]      rd_idx,
    output logic [`DC_INDEX_W-1:0]      wr_idx,
    output logic [`DC_WAYS-1:0]         tag_we,
    output dcache_pkg::tag_entry_t      tag_wr,
    output logic [`DC_WAYS-1:0]         line_we,
    output dcache_pkg::line_t           line_wr,
    output logic [`DC_WAYS-1:0]         dirty_we,
    output logic                        dirty_val,
    output logic [`DC_TAG_W-1:0]        req_tag,
    output logic [`DC_OFFSET_W-3:0]     req_offset,
    input  wire                         hit,
    input  wire dcache_pkg::way_id_t    hit_way,
    input  wire [31:0]                  hit_word,
    input  wire dcache_pkg::way_id_t    victim_way,
    input  wire                         victim_dirty,
    input  wire [`DC_TAG_W-1:0]         victim_tag,
    input  wire dcache_pkg::line_t      victim_line,
    output logic                        touch,
    output dcache_pkg::way_id_t         touch_way
);
    import dcache_pkg::*;

    localparam int off_w = `DC_OFFSET_W - 2;

    ctrl_state_t            state;
    logic [3:0]             wstrb_q;
    logic [31:0]            wdata_q;
    logic [off_w-1:0]       beat_q;      // shared by both bursts
    logic                   addr_done;   // aw or ar accepted
    logic                   w_done;
    logic                   resp_q;
    logic [31:0]            rdata_q;
    line_t                  fill_line;
    logic [31:0]            refill_word;
    logic                   lookup_hit;
    logic                   store_hit;
    logic                   beat_in;
    logic                   refill_end;
    way_id_t                wr_way;
    logic [`DC_WAYS-1:0]    way_oh;

    function automatic logic [31:0] merge_word(input logic [31:0] old_word);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (wstrb_q[b]) begin
                res[8*b +: 8] = wdata_q[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign lookup_hit  = (state == st_lookup) && hit;
    assign store_hit   = lookup_hit && |wstrb_q;
    assign beat_in     = (state == st_refill) && addr_done && r_valid;
    assign refill_end  = beat_in && r_last;
    assign refill_word = (beat_q == req_offset) ? merge_word(r_data) : r_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            beat_q    <= '0;
            addr_done <= 1'b0;
            w_done    <= 1'b0;
            resp_q    <= 1'b0;
            busy      <= 1'b0;
        end else begin
            resp_q <= refill_end;
            if ((state == st_lookup) && !hit) begin
                busy <= 1'b1;
            end else if (resp_q) begin
                busy <= 1'b0;     // one cycle after the miss response
            end
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        state <= st_idle;
                    end else begin
                        state <= victim_dirty ? st_wback : st_refill;
                    end
                end
                st_wback: begin
                    if (aw_valid && aw_ready) begin
                        addr_done <= 1'b1;
                    end
                    if (w_valid && w_ready) begin
                        beat_q <= beat_q + 1'b1;
                        w_done <= w_last;
                    end
                    if (w_done && b_valid) begin
                        addr_done <= 1'b0;
                        w_done    <= 1'b0;
                        state     <= st_refill;
                    end
                end
                default: begin
                    if (ar_valid && ar_ready) begin
                        addr_done <= 1'b1;
                    end
                    if (beat_in) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (refill_end) begin
                        addr_done <= 1'b0;
                        beat_q    <= '0;
                        state     <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && req) begin
            req_tag    <= addr[31 -: `DC_TAG_W];
            wr_idx     <= addr[`DC_OFFSET_W +: `DC_INDEX_W];
            req_offset <= addr[`DC_OFFSET_W-1:2];
            wstrb_q    <= wstrb;
            wdata_q    <= wdata;
        end
        if (beat_in) begin
            fill_line[beat_q] <= refill_word;
        end
        if (beat_in && (beat_q == req_offset)) begin
            rdata_q <= refill_word;   // answer for the miss
        end
    end

    // banks read straight off the core address
    assign rd_en  = (state == st_idle) && req;
    assign rd_idx = addr[`DC_OFFSET_W +: `DC_INDEX_W];

    assign ar_addr  = {req_tag, wr_idx, {`DC_OFFSET_W{1'b0}}};
    assign ar_valid = (state == st_refill) && !addr_done;
    assign aw_addr  = {victim_tag, wr_idx, {`DC_OFFSET_W{1'b0}}};
    assign aw_valid = (state == st_wback) && !addr_done;
    assign w_data   = victim_line[beat_q];
    assign w_valid  = (state == st_wback) && addr_done && !w_done;
    assign w_last   = beat_q == off_w'(`DC_WORDS - 1);

    assign wr_way    = lookup_hit ? hit_way : victim_way;
    assign way_oh    = {{(`DC_WAYS-1){1'b0}}, 1'b1} << wr_way;
    assign line_we   = (store_hit || beat_in) ? way_oh : '0;
    assign tag_we    = refill_end ? way_oh : '0;
    assign tag_wr    = '{valid: 1'b1, tag: req_tag};
    assign dirty_we  = (store_hit || refill_end) ? way_oh : '0;
    assign dirty_val = |wstrb_q;    // a load refill leaves the line clean

    // whole-line write, one word replaced
    always_comb begin
        if (state == st_refill) begin
            line_wr         = fill_line;
            line_wr[beat_q] = refill_word;
        end else begin
            line_wr             = victim_line;
            line_wr[req_offset] = merge_word(hit_word);
        end
    end

    assign touch     = lookup_hit || refill_end;
    assign touch_way = wr_way;

    assign resp  = lookup_hit || resp_q;
    assign rdata = (state == st_lookup) ? merge_word(hit_word) : rdata_q;

endmodule

`default_nettype wire

/* hdl/cache_way.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module cache_way (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        rd_en,
    input  wire [`DC_INDEX_W-1:0]      rd_idx,
    input  wire                        tag_we,
    input  wire [`DC_INDEX_W-1:0]      wr_idx,
    input  wire dcache_pkg::tag_entry_t tag_wr,
    input  wire                        line_we,
    input  wire dcache_pkg::line_t     line_wr,
    input  wire                        dirty_we,
    input  wire                        dirty_val,
    output dcache_pkg::tag_entry_t     tag_rd,
    output dcache_pkg::line_t          line_rd,
    output logic                       dirty_rd
);
    import dcache_pkg::*;

    localparam int sets = 1 << `DC_INDEX_W;

    tag_entry_t      tag_bank_rd;
    logic [sets-1:0] valid_q;      // one bit per set
    logic [sets-1:0] dirty_q;
    logic            valid_rd;

    sram_bank #(.entry_t(tag_entry_t), .depth(sets)) tag_bank (
        .clk    (clk),
        .rd_en  (rd_en),
        .rd_idx (rd_idx),
        .rd_data(tag_bank_rd),
        .wr_en  (tag_we),
        .wr_idx (wr_idx),
        .wr_data(tag_wr)
    );

    sram_bank #(.entry_t(line_t), .depth(sets)) data_bank (
        .clk    (clk),
        .rd_en  (rd_en),
        .rd_idx (rd_idx),
        .rd_data(line_rd),
        .wr_en  (line_we),
        .wr_idx (wr_idx),
        .wr_data(line_wr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            valid_rd <= 1'b0;
            dirty_rd <= 1'b0;
        end else begin
            if (tag_we) begin
                valid_q[wr_idx] <= tag_wr.valid;
            end
            if (dirty_we) begin
                dirty_q[wr_idx] <= dirty_val;
            end
            if (rd_en) begin    // same timing as the banks
                valid_rd <= valid_q[rd_idx];
                dirty_rd <= dirty_q[rd_idx];
            end
        end
    end

    assign tag_rd = '{valid: valid_rd, tag: tag_bank_rd.tag};

endmodule

`default_nettype wire

/* hdl/sram_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dcache_macros.svh"

module sram_bank #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 1 << `DC_INDEX_W
) (
    input  wire                     clk,
    input  wire                     rd_en,
    input  wire [$clog2(depth)-1:0] rd_idx,
    output entry_t                  rd_data,
    input  wire                     wr_en,
    input  wire [$clog2(depth)-1:0] wr_idx,
    input  wire entry_t             wr_data
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
        // old contents come out on a same-set write
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_pkg.sv */
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    // tag bank payload
    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    // data bank payload, word 0 in the low bits
    typedef logic [`DC_WORDS-1:0][31:0] line_t;

    typedef logic [1:0] way_id_t;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,     // banks hold the captured set
        st_wback,      // dirty victim burst out
        st_refill      // new line burst in
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry, 4 ways x 16 sets x 16-byte lines

`define DC_WAYS      4
`define DC_INDEX_W   4      // 16 sets
`define DC_OFFSET_W  4      // byte offset within a line
`define DC_WORDS     4      // 32-bit words per line

// whatever is left of a 32-bit address
`define DC_TAG_W     (32 - `DC_INDEX_W - `DC_OFFSET_W)

`endif
